//--- source/kernel_loader_pkg.sv
// shared widths, bus constants and sequencer states
// for the weight-tile loader

package kernel_loader_pkg;

  // ====================
  // widths
  // ====================
  localparam int ADDR_W = 32;  // addresses and cfg registers
  localparam int ELEM_W = 8;   // one int8 weight

  // ====================
  // icb read bus
  // ====================
  localparam int BUS_W          = 32;          // fixed 32-bit data bus
  localparam int BYTES_PER_BEAT = BUS_W / 8;   // elements per rsp beat

  // sequencer states
  typedef enum logic [2:0] {
    IDLE       = 3'd0,  // waiting for init_cfg
    WAIT_GRANT = 3'd1,  // req raised, no grant yet
    LOAD       = 3'd2,  // bursts in flight
    READY      = 3'd3,  // tile buffered, waiting for trigger
    SEND       = 3'd4   // rows going out to the array
  } loader_state_t;

endpackage

//--- source/tile_sequencer.sv
// tile sequencer: latches the gemm config, walks row tiles, column tiles and passes,
// runs the req/grant and data-valid handshakes, hands tile address and edge sizes on
`timescale 1ns/1ns

module tile_sequencer
  import kernel_loader_pkg::*;
#(
  parameter int SIZE = 16
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     init_cfg,
  input  logic [ADDR_W-1:0]        k,
  input  logic [ADDR_W-1:0]        n,
  input  logic [ADDR_W-1:0]        m,
  input  logic [ADDR_W-1:0]        rhs_zp,
  input  logic [ADDR_W-1:0]        rhs_col_stride_b,
  input  logic [ADDR_W-1:0]        rhs_base,
  input  logic                     load_weight_granted,
  input  logic                     send_weight_trigger,
  input  logic                     tile_filled,
  input  logic                     tile_sent,
  output logic                     load_weight_req,
  output logic                     weight_data_valid,
  output logic                     tile_start,
  output logic [ADDR_W-1:0]        tile_addr,
  output logic [ADDR_W-1:0]        stride,
  output logic [ELEM_W-1:0]        zp,
  output logic [$clog2(SIZE):0]    valid_rows,
  output logic [$clog2(SIZE):0]    valid_cols
);

  localparam int LOG   = $clog2(SIZE);
  localparam int CNT_W = LOG + 1;

  loader_state_t state;

  logic [ADDR_W-1:0] row_tiles, col_tiles, passes;  // ceil(n|m|k / SIZE)
  logic [LOG-1:0]    row_rem, col_rem;              // edge remainders, 0 = full
  logic [ADDR_W-1:0] base;
  logic [ADDR_W-1:0] tr, tc, pass_cnt;              // tile walk indices
  logic [ADDR_W-1:0] col_base;                      // first tile of current col group
  logic [ADDR_W-1:0] col_step;
  logic              wdv_q;
  logic              last_tr, last_tc, last_pass, last_tile;

  assign col_step  = stride << LOG;  // SIZE columns further on
  assign last_tr   = (tr == row_tiles - 1'b1);
  assign last_tc   = (tc == col_tiles - 1'b1);
  assign last_pass = (pass_cnt == passes - 1'b1);
  assign last_tile = last_tr && last_tc && last_pass;

  // partial tile only on the bottom / right edge
  assign valid_rows = (last_tr && row_rem != '0) ? {1'b0, row_rem} : CNT_W'(SIZE);
  assign valid_cols = (last_tc && col_rem != '0) ? {1'b0, col_rem} : CNT_W'(SIZE);

  // tile_filled lets the level rise right after the last beat
  assign weight_data_valid = wdv_q | tile_filled;

  // ====================
  // configuration
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_tiles <= '0;
      col_tiles <= '0;
      passes    <= '0;
      row_rem   <= '0;
      col_rem   <= '0;
    end else if (state == IDLE && init_cfg) begin
      row_tiles <= (n + ADDR_W'(SIZE - 1)) >> LOG;
      col_tiles <= (m + ADDR_W'(SIZE - 1)) >> LOG;
      passes    <= (k + ADDR_W'(SIZE - 1)) >> LOG;
      row_rem   <= n[LOG-1:0];  // n mod SIZE
      col_rem   <= m[LOG-1:0];
    end
  end

  // payload side of the cfg
  always_ff @(posedge clk) begin
    if (state == IDLE && init_cfg) begin
      base   <= rhs_base;
      stride <= rhs_col_stride_b;
      zp     <= rhs_zp[ELEM_W-1:0];  // only the low byte matters for int8
    end
  end

  // ====================
  // fsm and tile walk
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state           <= IDLE;
      load_weight_req <= 1'b0;
      tile_start      <= 1'b0;
      wdv_q           <= 1'b0;
      tr              <= '0;
      tc              <= '0;
      pass_cnt        <= '0;
      tile_addr       <= '0;
      col_base        <= '0;
    end else begin
      tile_start <= 1'b0;  // single-cycle pulse
      case (state)
        IDLE: begin
          if (init_cfg) begin
            load_weight_req <= 1'b1;
            tr              <= '0;
            tc              <= '0;
            pass_cnt        <= '0;
            tile_addr       <= rhs_base;
            col_base        <= rhs_base;
            state           <= WAIT_GRANT;
          end
        end
        WAIT_GRANT: begin
          if (load_weight_granted) begin
            load_weight_req <= 1'b0;
            tile_start      <= 1'b1;  // issuer fires next cycle
            state           <= LOAD;
          end
        end
        LOAD: begin
          if (tile_filled) begin
            if (send_weight_trigger) begin
              state <= SEND;  // trigger caught on the rising cycle
            end else begin
              wdv_q <= 1'b1;
              state <= READY;
            end
          end
        end
        READY: begin
          if (send_weight_trigger) begin
            wdv_q <= 1'b0;
            state <= SEND;
          end
        end
        SEND: begin
          if (tile_sent) begin
            if (last_tile) begin
              state <= IDLE;  // whole matrix done, no more req
            end else begin
              load_weight_req <= 1'b1;
              state           <= WAIT_GRANT;
              if (!last_tr) begin
                tr        <= tr + 1'b1;
                tile_addr <= tile_addr + ADDR_W'(SIZE);  // SIZE bytes down the column
              end else if (!last_tc) begin
                tr        <= '0;
                tc        <= tc + 1'b1;
                col_base  <= col_base + col_step;
                tile_addr <= col_base + col_step;
              end else begin
                // next pass reuses the whole weight set
                tr        <= '0;
                tc        <= '0;
                pass_cnt  <= pass_cnt + 1'b1;
                col_base  <= base;
                tile_addr <= base;
              end
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- source/column_read_issuer.sv
// column read issuer that sends one icb read burst per valid column of the tile
// and holds each command while the bus stalls
`timescale 1ns/1ns

module column_read_issuer
  import kernel_loader_pkg::*;
#(
  parameter int SIZE = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  tile_start,
  input  logic [ADDR_W-1:0]     tile_addr,
  input  logic [ADDR_W-1:0]     stride,
  input  logic [$clog2(SIZE):0] valid_rows,
  input  logic [$clog2(SIZE):0] valid_cols,
  input  logic                  icb_cmd_ready,
  output logic                  icb_cmd_valid,
  output logic [ADDR_W-1:0]     icb_cmd_addr,
  output logic [3:0]            icb_cmd_len
);

  localparam int CNT_W    = $clog2(SIZE) + 1;
  localparam int BEAT_SH  = $clog2(BYTES_PER_BEAT);

  logic [CNT_W-1:0]  col_cnt;    // commands issued so far including the current one
  logic [ADDR_W-1:0] next_addr;  // address of the following column
  logic [CNT_W-1:0]  beats;
  logic              cmd_hs;

  assign cmd_hs = icb_cmd_valid && icb_cmd_ready;

  // len is ceil(valid_rows / 4) beats minus one
  assign beats       = (valid_rows + CNT_W'(BYTES_PER_BEAT - 1)) >> BEAT_SH;
  assign icb_cmd_len = 4'(beats - 1'b1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      icb_cmd_valid <= 1'b0;
      col_cnt       <= '0;
    end else if (tile_start) begin
      icb_cmd_valid <= 1'b1;  // first column straight away
      col_cnt       <= CNT_W'(1);
    end else if (cmd_hs) begin
      if (col_cnt == valid_cols) begin
        icb_cmd_valid <= 1'b0;  // last column accepted
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  // column address path
  always_ff @(posedge clk) begin
    if (tile_start) begin
      icb_cmd_addr <= tile_addr;
      next_addr    <= tile_addr + stride;
    end else if (cmd_hs && col_cnt != valid_cols) begin
      icb_cmd_addr <= next_addr;       // advance only on accept
      next_addr    <= next_addr + stride;
    end
  end

endmodule

//--- source/weight_tile_buffer.sv
// weight tile buffer: unpacks response beats, adds the zero point,
// stores by column and row and reads one row back out across all columns
`timescale 1ns/1ns

module weight_tile_buffer
  import kernel_loader_pkg::*;
#(
  parameter int SIZE = 16
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     tile_start,
  input  logic [ELEM_W-1:0]        zp,
  input  logic [$clog2(SIZE):0]    valid_rows,
  input  logic [$clog2(SIZE):0]    valid_cols,
  input  logic                     icb_rsp_valid,
  input  logic [BUS_W-1:0]         icb_rsp_rdata,
  input  logic [$clog2(SIZE)-1:0]  rd_row,
  output logic                     icb_rsp_ready,
  output logic                     tile_filled,
  output logic [SIZE*ELEM_W-1:0]   row_data
);

  localparam int RD_W    = $clog2(SIZE);
  localparam int CNT_W   = RD_W + 1;
  localparam int ROW_W   = RD_W + 1;  // room for rows past SIZE
  localparam int BEAT_SH = $clog2(BYTES_PER_BEAT);

  logic [ELEM_W-1:0] mem [SIZE][SIZE];  // [col][row]

  logic [RD_W-1:0]  beat_cnt;   // beat within column
  logic [RD_W-1:0]  col_cnt;    // column within tile
  logic [CNT_W-1:0] beats;      // beats per column
  logic [ROW_W-1:0] beat_base;  // first row of this beat
  logic             rsp_hs;
  logic             last_beat, last_col;

  assign rsp_hs    = icb_rsp_valid && icb_rsp_ready;
  assign beats     = (valid_rows + CNT_W'(BYTES_PER_BEAT - 1)) >> BEAT_SH;
  assign beat_base = ROW_W'(beat_cnt) << BEAT_SH;
  assign last_beat = (CNT_W'(beat_cnt) == beats - 1'b1);
  assign last_col  = (CNT_W'(col_cnt) == valid_cols - 1'b1);

  // ====================
  // beat / column count
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      icb_rsp_ready <= 1'b0;
      tile_filled   <= 1'b0;
      beat_cnt      <= '0;
      col_cnt       <= '0;
    end else begin
      tile_filled <= 1'b0;
      if (tile_start) begin
        icb_rsp_ready <= 1'b1;  // open for the whole load
        beat_cnt      <= '0;
        col_cnt       <= '0;
      end else if (rsp_hs) begin
        if (last_beat) begin
          beat_cnt <= '0;
          if (last_col) begin
            col_cnt       <= '0;
            icb_rsp_ready <= 1'b0;
            tile_filled   <= 1'b1;  // one cycle after the final beat
          end else begin
            col_cnt <= col_cnt + 1'b1;
          end
        end else begin
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
    end
  end

  // byte unpack with zero point, wraps to 8 bits
  always_ff @(posedge clk) begin
    if (rsp_hs) begin
      for (int b = 0; b < BYTES_PER_BEAT; b++) begin
        if (beat_base + ROW_W'(b) < ROW_W'(SIZE)) begin  // drop bytes past SIZE
          mem[col_cnt][RD_W'(beat_base + ROW_W'(b))] <= icb_rsp_rdata[b*ELEM_W +: ELEM_W] + zp;
        end
      end
    end
  end

  // one row across all columns
  always_comb begin
    for (int c = 0; c < SIZE; c++) begin
      row_data[c*ELEM_W +: ELEM_W] = mem[c][rd_row];
    end
  end

endmodule

//--- source/row_sender.sv
// row sender: walks the buffered tile from the last row down to row 0,
// zeroes padding rows and columns, flags the final row
`timescale 1ns/1ns

module row_sender
  import kernel_loader_pkg::*;
#(
  parameter int SIZE = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           weight_data_valid,
  input  logic                           send_weight_trigger,
  input  logic [$clog2(SIZE):0]          valid_rows,
  input  logic [$clog2(SIZE):0]          valid_cols,
  input  logic [SIZE*ELEM_W-1:0]         row_data,
  output logic [$clog2(SIZE)-1:0]        rd_row,
  output logic                           weight_row_valid,
  output logic signed [ELEM_W-1:0]       weight_out [SIZE],
  output logic                           weight_sending_done,
  output logic                           tile_sent
);

  localparam int CNT_W = $clog2(SIZE) + 1;

  logic row_ok;  // current row inside the matrix

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      weight_row_valid <= 1'b0;
      rd_row           <= '0;
    end else if (!weight_row_valid) begin
      if (send_weight_trigger && weight_data_valid) begin
        weight_row_valid <= 1'b1;
        rd_row           <= '1;  // SIZE-1, last row first
      end
    end else if (rd_row == '0) begin
      weight_row_valid <= 1'b0;  // SIZE rows out
    end else begin
      rd_row <= rd_row - 1'b1;
    end
  end

  assign weight_sending_done = weight_row_valid && (rd_row == '0);
  assign tile_sent           = weight_sending_done;  // sequencer copy

  assign row_ok = weight_row_valid && (CNT_W'(rd_row) < valid_rows);

  // padding goes out as zero
  always_comb begin
    for (int i = 0; i < SIZE; i++) begin
      weight_out[i] = (row_ok && CNT_W'(i) < valid_cols) ?
                      $signed(row_data[i*ELEM_W +: ELEM_W]) : '0;
    end
  end

endmodule

//--- source/kernel_loader.sv
// weight-tile loader top: fetches column-major int8 weight tiles over icb
// and pushes them row by row, last row first, into the systolic array
`timescale 1ns/1ns

module kernel_loader
  import kernel_loader_pkg::*;
#(
  parameter int SIZE = 16  // array dimension, power of two, >= 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // configuration
  input  logic                      init_cfg,
  input  logic [ADDR_W-1:0]         k,
  input  logic [ADDR_W-1:0]         n,
  input  logic [ADDR_W-1:0]         m,
  input  logic [ADDR_W-1:0]         rhs_zp,
  input  logic [ADDR_W-1:0]         rhs_col_stride_b,
  input  logic [ADDR_W-1:0]         rhs_base,
  // req/grant and send control
  output logic                      load_weight_req,
  input  logic                      load_weight_granted,
  input  logic                      send_weight_trigger,
  output logic                      weight_data_valid,
  // icb command
  output logic                      icb_cmd_valid,
  input  logic                      icb_cmd_ready,
  output logic [ADDR_W-1:0]         icb_cmd_addr,
  output logic [3:0]                icb_cmd_len,
  // icb response
  input  logic                      icb_rsp_valid,
  output logic                      icb_rsp_ready,
  input  logic [BUS_W-1:0]          icb_rsp_rdata,
  // to the array
  output logic                      weight_row_valid,
  output logic signed [ELEM_W-1:0]  weight_out [SIZE],
  output logic                      weight_sending_done
);

  localparam int RD_W = $clog2(SIZE);

  // ====================
  // internal nets
  // ====================
  logic                   tile_start;
  logic [ADDR_W-1:0]      tile_addr;
  logic [ADDR_W-1:0]      stride;
  logic [ELEM_W-1:0]      zp;
  logic [RD_W:0]          valid_rows, valid_cols;
  logic                   tile_filled;
  logic                   tile_sent;
  logic [RD_W-1:0]        rd_row;
  logic [SIZE*ELEM_W-1:0] row_data;

  tile_sequencer #(.SIZE(SIZE)) u_seq (
    .clk                 (clk),
    .rst_n               (rst_n),
    .init_cfg            (init_cfg),
    .k                   (k),
    .n                   (n),
    .m                   (m),
    .rhs_zp              (rhs_zp),
    .rhs_col_stride_b    (rhs_col_stride_b),
    .rhs_base            (rhs_base),
    .load_weight_granted (load_weight_granted),
    .send_weight_trigger (send_weight_trigger),
    .tile_filled         (tile_filled),
    .tile_sent           (tile_sent),
    .load_weight_req     (load_weight_req),
    .weight_data_valid   (weight_data_valid),
    .tile_start          (tile_start),
    .tile_addr           (tile_addr),
    .stride              (stride),
    .zp                  (zp),
    .valid_rows          (valid_rows),
    .valid_cols          (valid_cols)
  );

  column_read_issuer #(.SIZE(SIZE)) u_issuer (
    .clk           (clk),
    .rst_n         (rst_n),
    .tile_start    (tile_start),
    .tile_addr     (tile_addr),
    .stride        (stride),
    .valid_rows    (valid_rows),
    .valid_cols    (valid_cols),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_addr  (icb_cmd_addr),
    .icb_cmd_len   (icb_cmd_len)
  );

  weight_tile_buffer #(.SIZE(SIZE)) u_buf (
    .clk           (clk),
    .rst_n         (rst_n),
    .tile_start    (tile_start),
    .zp            (zp),
    .valid_rows    (valid_rows),
    .valid_cols    (valid_cols),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp_rdata (icb_rsp_rdata),
    .rd_row        (rd_row),
    .icb_rsp_ready (icb_rsp_ready),
    .tile_filled   (tile_filled),
    .row_data      (row_data)
  );

  row_sender #(.SIZE(SIZE)) u_send (
    .clk                 (clk),
    .rst_n               (rst_n),
    .weight_data_valid   (weight_data_valid),
    .send_weight_trigger (send_weight_trigger),
    .valid_rows          (valid_rows),
    .valid_cols          (valid_cols),
    .row_data            (row_data),
    .rd_row              (rd_row),
    .weight_row_valid    (weight_row_valid),
    .weight_out          (weight_out),
    .weight_sending_done (weight_sending_done),
    .tile_sent           (tile_sent)
  );

endmodule

//--- tests/loader_props.sv
// concurrent assertions on the icb command hold, send framing and request rules
`timescale 1ns/1ns

module loader_props
  import kernel_loader_pkg::*;
(
  input logic              clk,
  input logic              rst_n,
  input logic              init_cfg,
  input logic              load_weight_req,
  input logic              send_weight_trigger,
  input logic              weight_data_valid,
  input logic              icb_cmd_valid,
  input logic              icb_cmd_ready,
  input logic [ADDR_W-1:0] icb_cmd_addr,
  input logic [3:0]        icb_cmd_len,
  input logic              weight_row_valid,
  input logic              weight_sending_done
);

  // stalled command keeps addr and len
  cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    icb_cmd_valid && !icb_cmd_ready |=>
      icb_cmd_valid && $stable(icb_cmd_addr) && $stable(icb_cmd_len))
    else $error("icb command changed while stalled");

  done_is_last: assert property (@(posedge clk) disable iff (!rst_n)
    weight_sending_done |=> !weight_row_valid)
    else $error("rows continued after sending done");

  // first row one cycle after the accepted trigger
  row_start: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(weight_row_valid) |-> $past(send_weight_trigger && weight_data_valid))
    else $error("rows started without a trigger");

  wdv_not_in_send: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(weight_data_valid) |-> !weight_row_valid)
    else $error("data valid rose while sending");

  req_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(load_weight_req) |-> $past(init_cfg) || $past(weight_sending_done))
    else $error("request rose without init or tile end");

endmodule

bind kernel_loader loader_props props0 (
  .clk                 (clk),
  .rst_n               (rst_n),
  .init_cfg            (init_cfg),
  .load_weight_req     (load_weight_req),
  .send_weight_trigger (send_weight_trigger),
  .weight_data_valid   (weight_data_valid),
  .icb_cmd_valid       (icb_cmd_valid),
  .icb_cmd_ready       (icb_cmd_ready),
  .icb_cmd_addr        (icb_cmd_addr),
  .icb_cmd_len         (icb_cmd_len),
  .weight_row_valid    (weight_row_valid),
  .weight_sending_done (weight_sending_done)
);

//--- tests/loader_checker.sv
// checker that mirrors the loader's tile walk, works out each expected row
// and compares it with the rows sent to the array
`timescale 1ns/1ns

module loader_checker
  import kernel_loader_pkg::*;
#(
  parameter int SIZE = 8
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     init_cfg,
  input  logic [ADDR_W-1:0]        k,
  input  logic [ADDR_W-1:0]        n,
  input  logic [ADDR_W-1:0]        m,
  input  logic [ADDR_W-1:0]        rhs_zp,
  input  logic [ADDR_W-1:0]        rhs_col_stride_b,
  input  logic [ADDR_W-1:0]        rhs_base,
  input  logic                     load_weight_req,
  input  logic                     send_weight_trigger,
  input  logic                     weight_data_valid,
  input  logic                     weight_row_valid,
  input  logic                     weight_sending_done,
  input  logic signed [ELEM_W-1:0] weight_out [SIZE],
  output int                       errors,
  output logic                     walk_done
);

  logic [ADDR_W-1:0]        n_q, m_q, base_q, stride_q;
  logic [ELEM_W-1:0]        zp_q;
  int                       row_tiles, col_tiles;
  int                       tr, tc, ps;   // tile walk in loader order
  int                       row;          // next expected row, counting down
  int                       tiles_left;
  int                       bad;
  logic                     armed;        // trigger accepted last cycle
  logic                     req_q;
  logic signed [ELEM_W-1:0] exp_v;

  // low byte of a ^ (a >> 8) ^ 5a as the memory image
  function automatic logic [ELEM_W-1:0] mem_byte(input logic [ADDR_W-1:0] a);
    return ELEM_W'(a ^ (a >> 8) ^ 32'h5a);
  endfunction

  // expected element for tile (t_r, t_c), row r_i, column c_i
  function automatic logic [ELEM_W-1:0] expected_weight(input int t_r, input int t_c,
                                                         input int r_i, input int c_i);
    logic [ADDR_W-1:0] r;
    logic [ADDR_W-1:0] c;
    r = ADDR_W'(t_r * SIZE + r_i);
    c = ADDR_W'(t_c * SIZE + c_i);
    if (r >= n_q || c >= m_q) return '0;  // padding
    return mem_byte(base_q + c * stride_q + r) + zp_q;  // wraps to 8 bits
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      errors    <= 0;
      walk_done <= 1'b1;
      armed     <= 1'b0;
      req_q     <= 1'b0;
      row       <= SIZE - 1;
    end else begin
      bad = 0;
      armed <= send_weight_trigger && weight_data_valid && !weight_row_valid;
      req_q <= load_weight_req;
      // ====================
      // new configuration
      // ====================
      if (init_cfg && walk_done) begin
        n_q        <= n;
        m_q        <= m;
        base_q     <= rhs_base;
        stride_q   <= rhs_col_stride_b;
        zp_q       <= rhs_zp[ELEM_W-1:0];
        row_tiles  <= (int'(n) + SIZE - 1) / SIZE;
        col_tiles  <= (int'(m) + SIZE - 1) / SIZE;
        tiles_left <= ((int'(n) + SIZE - 1) / SIZE) * ((int'(m) + SIZE - 1) / SIZE)
                      * ((int'(k) + SIZE - 1) / SIZE);
        tr         <= 0;
        tc         <= 0;
        ps         <= 0;
        walk_done  <= 1'b0;
      end
      if (load_weight_req && !req_q && walk_done) begin
        $display("%0t: request raised after the final tile", $time);
        bad++;
      end
      if (armed && !weight_row_valid) begin
        $display("%0t: no row one cycle after the trigger", $time);
        bad++;
      end
      // ====================
      // row compare
      // ====================
      if (weight_row_valid && walk_done) begin
        $display("%0t: row sent with no tile left in the walk", $time);
        bad++;
      end else if (weight_row_valid) begin
        if (row == SIZE - 1 && !armed) begin
          $display("%0t: rows started without a trigger", $time);
          bad++;
        end
        for (int c = 0; c < SIZE; c++) begin
          exp_v = expected_weight(tr, tc, row, c);
          if (weight_out[c] !== exp_v) begin
            $display("mismatch at %0t: weight_out[%0d] got %0d expected %0d, pass %0d row %0d",
                     $time, c, weight_out[c], exp_v, ps, row);
            bad++;
          end
        end
        if (weight_sending_done !== (row == 0)) begin
          $display("mismatch at %0t: weight_sending_done got %0b expected %0b",
                   $time, weight_sending_done, row == 0);
          bad++;
        end
        if (row == 0) begin  // tile done so step the walk
          row        <= SIZE - 1;
          tiles_left <= tiles_left - 1;
          if (tiles_left == 1) walk_done <= 1'b1;
          if (tr < row_tiles - 1) begin
            tr <= tr + 1;
          end else begin
            tr <= 0;
            if (tc < col_tiles - 1) begin
              tc <= tc + 1;
            end else begin
              tc <= 0;
              ps <= ps + 1;  // next pass over the same tiles
            end
          end
        end else begin
          row <= row - 1;
        end
      end else begin
        if (row != SIZE - 1) begin
          $display("%0t: row burst ended after %0d rows", $time, SIZE - 1 - row);
          bad++;
          row <= SIZE - 1;
        end
        if (weight_sending_done) begin
          $display("%0t: sending done high with no row valid", $time);
          bad++;
        end
      end
      errors <= errors + bad;
    end
  end

endmodule

//--- tests/tb_kernel_loader.sv
// testbench top for the weight-tile loader: clock, reset, config runs,
// grant and trigger replies, icb memory model and run timeout
`timescale 1ns/1ns

module tb_kernel_loader;
  import kernel_loader_pkg::*;

  localparam int SIZE    = 8;
  localparam int TILES   = 1 + 12 + 12 + 2;      // summed over the four runs
  localparam int TIMEOUT = 300 * TILES + 500;

  logic                     clk, rst_n, init_cfg;
  logic [ADDR_W-1:0]        k, n, m, rhs_zp, rhs_col_stride_b, rhs_base;
  logic                     load_weight_req, load_weight_granted;
  logic                     send_weight_trigger, weight_data_valid;
  logic                     icb_cmd_valid, icb_cmd_ready;
  logic [ADDR_W-1:0]        icb_cmd_addr;
  logic [3:0]               icb_cmd_len;
  logic                     icb_rsp_valid, icb_rsp_ready;
  logic [BUS_W-1:0]         icb_rsp_rdata;
  logic                     weight_row_valid, weight_sending_done;
  logic signed [ELEM_W-1:0] weight_out [SIZE];

  logic [31:0]       rng;
  logic              stall_mode;       // random cmd ready when set
  logic [ADDR_W-1:0] beat_q[$];        // pending response beats
  int                due_q[$];         // cycle each beat may go out
  int                cycles, grants, lat, trig_cnt, trig_delay, tb_errors, chk_errors;
  logic              walk_done;

  kernel_loader #(.SIZE(SIZE)) dut0 (.*);

  loader_checker #(.SIZE(SIZE)) chk0 (
    .clk (clk), .rst_n (rst_n), .init_cfg (init_cfg),
    .k (k), .n (n), .m (m), .rhs_zp (rhs_zp),
    .rhs_col_stride_b (rhs_col_stride_b), .rhs_base (rhs_base),
    .load_weight_req (load_weight_req), .send_weight_trigger (send_weight_trigger),
    .weight_data_valid (weight_data_valid), .weight_row_valid (weight_row_valid),
    .weight_sending_done (weight_sending_done), .weight_out (weight_out),
    .errors (chk_errors), .walk_done (walk_done)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [7:0] mem_byte(input logic [ADDR_W-1:0] a);
    return 8'(a ^ (a >> 8) ^ 32'h5a);
  endfunction

  function automatic logic [BUS_W-1:0] beat_word(input logic [ADDR_W-1:0] a);
    return {mem_byte(a + 3), mem_byte(a + 2), mem_byte(a + 1), mem_byte(a)};  // little endian
  endfunction

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ====================
  // grant, trigger, icb memory
  // ====================
  always @(posedge clk) begin
    if (rst_n) begin
      rng = xorshift32(rng);
      load_weight_granted <= load_weight_req && !load_weight_granted;  // one cycle later
      if (load_weight_req && !load_weight_granted) grants <= grants + 1;
      if (send_weight_trigger) begin
        send_weight_trigger <= 1'b0;
        trig_cnt            <= 0;
        trig_delay          <= int'(rng[25:24]) % 3;
      end else if (weight_data_valid) begin
        if (trig_cnt >= trig_delay) send_weight_trigger <= 1'b1;
        else trig_cnt <= trig_cnt + 1;
      end
      icb_cmd_ready <= stall_mode ? rng[7] : 1'b1;
      if (icb_rsp_valid && icb_rsp_ready) begin
        void'(beat_q.pop_front());
        void'(due_q.pop_front());
      end
      if (icb_cmd_valid && icb_cmd_ready) begin
        lat = int'(rng[17:16]) % 3 + 1;  // 1 to 3 cycles
        for (int i = 0; i <= int'(icb_cmd_len); i++) begin
          beat_q.push_back(icb_cmd_addr + ADDR_W'(4 * i));
          due_q.push_back(cycles + lat);
        end
      end
      if (beat_q.size() > 0 && due_q[0] <= cycles) begin
        icb_rsp_valid <= 1'b1;
        icb_rsp_rdata <= beat_word(beat_q[0]);
      end else begin
        icb_rsp_valid <= 1'b0;
      end
    end
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT) begin
      $display("timeout: the tile walk did not finish within %0d cycles", TIMEOUT);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic run_walk(input logic [ADDR_W-1:0] kk, input logic [ADDR_W-1:0] nn,
                          input logic [ADDR_W-1:0] mm, input logic [ADDR_W-1:0] zpv,
                          input logic [ADDR_W-1:0] str, input logic [ADDR_W-1:0] bas,
                          input logic stall, input int tiles);
    int g0;
    logic late_req;
    g0       = grants;
    late_req = 1'b0;
    k                <= kk;
    n                <= nn;
    m                <= mm;
    rhs_zp           <= zpv;
    rhs_col_stride_b <= str;
    rhs_base         <= bas;
    stall_mode       <= stall;
    init_cfg         <= 1'b1;
    @(posedge clk);
    init_cfg <= 1'b0;
    do @(posedge clk); while (!walk_done);
    repeat (20) begin  // idle, no new request
      @(posedge clk);
      late_req = late_req | load_weight_req;
    end
    if (late_req) begin
      $display("%0t: request raised after the final tile", $time);
      tb_errors++;
    end
    if (grants - g0 != tiles) begin
      $display("mismatch at %0t: request count got %0d expected %0d", $time, grants - g0, tiles);
      tb_errors++;
    end
  endtask

  initial begin
    rst_n = 1'b0;
    init_cfg = 1'b0;
    {k, n, m, rhs_zp, rhs_col_stride_b, rhs_base} = '0;
    load_weight_granted = 1'b0;
    send_weight_trigger = 1'b0;
    icb_cmd_ready = 1'b0;
    icb_rsp_valid = 1'b0;
    icb_rsp_rdata = '0;
    rng = 32'hc77e;
    stall_mode = 1'b0;
    {cycles, grants, trig_cnt, trig_delay, tb_errors} = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (load_weight_req || icb_cmd_valid || icb_rsp_ready || weight_data_valid ||
        weight_row_valid || weight_sending_done) begin
      $display("%0t: control output high right after reset", $time);
      tb_errors++;
    end
    run_walk(8, 8, 8, 0, 8, 32'h1000, 1'b0, 1);                // single tile
    run_walk(10, 12, 20, 3, 20, 32'h2000, 1'b0, 12);           // edges and zero point
    run_walk(10, 12, 20, 3, 20, 32'h2000, 1'b1, 12);           // same walk, stalled bus
    run_walk(3, 5, 9, 32'h1234_56f0, 12, 32'h3a00, 1'b1, 2);   // reconfigured, zp wraps
    $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- compile.f
source/kernel_loader_pkg.sv
source/tile_sequencer.sv
source/column_read_issuer.sv
source/weight_tile_buffer.sv
source/row_sender.sv
source/kernel_loader.sv
tests/loader_props.sv
tests/loader_checker.sv
tests/tb_kernel_loader.sv

//--- Makefile
# Verilator build and run of the weight-tile loader testbench
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_kernel_loader -f compile.f
	@out=$$(./obj_dir/Vtb_kernel_loader); echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
